//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = flow_led_tb
FILELIST = flow_led.f
LOG      = sim.log
PASS     = All tests passed!

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '$(PASS)' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- dv/flow_led_tb.sv
`timescale 1ns/1ps
`include "flow_led_settings.svh"

module flow_led_tb;

  localparam int CPB       = `FLOW_LED_CLKS_PER_BIT;
  localparam int FRAME_CYC = 35 * `FLOW_LED_SEG_DIV; // Load, 32 bit halves, 2 strobe steps
  // About 70 UART bytes in all tests, rounded up, plus display scans
  localparam int WATCHDOG_NS = (100 * 10 * CPB + 20 * FRAME_CYC) * 4;

  // Common-anode codes, dp g f e d c b a, active low
  localparam logic [7:0] SEG_TABLE [16] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
  };

  logic        sys_clk;
  logic        arst_n;
  logic        key2;
  logic        uart_rx_from_pc;
  logic        uart_tx_to_pc;
  logic        led;
  logic        segled_clk;
  logic        segled_dat;
  logic        segled_str;
  logic [15:0] seg_frame;
  logic [7:0]  last_seg [4];
  int          seed = 27;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          test_errs = 0;
  string       cur_test;

  flow_led i_flow_led (
    .sys_clk         (sys_clk),
    .arst_n          (arst_n),
    .key2            (key2),
    .uart_rx_from_pc (uart_rx_from_pc),
    .uart_tx_to_pc   (uart_tx_to_pc),
    .led             (led),
    .segled_clk      (segled_clk),
    .segled_dat      (segled_dat),
    .segled_str      (segled_str)
  );

  initial sys_clk = 1'b0;
  always #2 sys_clk = ~sys_clk;

  // 595 chain model, segment byte first then digit select
  always @(posedge segled_clk) seg_frame <= {seg_frame[14:0], segled_dat};

  always @(posedge segled_str) begin
    for (int d = 0; d < 4; d++) begin
      if (!seg_frame[d]) last_seg[d] <= seg_frame[15:8]; // Active low select
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("Test %s: ok", cur_test);
      pass_cnt++;
    end else begin
      $display("Test %s: %0d check(s) failed", cur_test, test_errs);
      fail_cnt++;
    end
  endtask

  task automatic compare_value(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAILED %s (%s): expected %02h, actual %02h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic uart_send(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0}; // Stop, data LSB first, start
    @(negedge sys_clk);
    for (int i = 0; i < 10; i++) begin
      uart_rx_from_pc = frame[i];
      repeat (CPB) @(negedge sys_clk);
    end
  endtask

  task automatic uart_recv(output logic [7:0] data);
    @(negedge uart_tx_to_pc); // Start bit
    repeat (CPB / 2) @(negedge sys_clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge sys_clk);
      data[i] = uart_tx_to_pc;
    end
    repeat (CPB) @(negedge sys_clk);
    if (uart_tx_to_pc !== 1'b1) begin
      $display("FAILED %s: the stop bit of a response byte was low", cur_test);
      test_errs++;
    end
  endtask

  task automatic write_reg(input logic [2:0] idx, input logic [7:0] data);
    uart_send({5'b10000, idx});
    uart_send(data);
  endtask

  task automatic read_reg(input logic [3:0] idx, output logic [7:0] data);
    fork
      uart_send({4'h0, idx});
      uart_recv(data);
    join
  endtask

  task automatic test_reset();
    logic [7:0] got;
    start_test("reset_state");
    compare_value("uart_tx_to_pc", 8'h01, {7'd0, uart_tx_to_pc});
    compare_value("led", 8'h00, {7'd0, led});
    read_reg(4'd0, got);
    compare_value("index 0", 8'h00, got);
    read_reg(4'd9, got);
    compare_value("write count", 8'h00, got);
    end_test();
  endtask

  task automatic test_write_read();
    logic [7:0] vals [8];
    logic [7:0] got;
    start_test("write_read");
    for (int i = 0; i < 8; i++) begin
      vals[i] = 8'($random(seed));
      write_reg(3'(i), vals[i]);
    end
    for (int i = 0; i < 8; i++) begin
      read_reg(4'(i), got);
      compare_value($sformatf("register %0d", i), vals[i], got);
    end
    read_reg(4'd9, got);
    compare_value("write count", 8'h08, got);
    end_test();
  endtask

  task automatic test_key();
    logic [7:0] got;
    start_test("key_input");
    @(negedge sys_clk) key2 = 1'b0;
    read_reg(4'd8, got);
    compare_value("key low", 8'h00, got);
    @(negedge sys_clk) key2 = 1'b1;
    read_reg(4'd8, got);
    compare_value("key high", 8'h01, got);
    for (int i = 10; i < 16; i++) begin
      read_reg(4'(i), got);
      compare_value($sformatf("index %0d", i), 8'h00, got);
    end
    @(negedge sys_clk) key2 = 1'b0;
    end_test();
  endtask

  task automatic test_display();
    logic [7:0] vals [4];
    start_test("display");
    vals = '{8'h03, 8'h0A, 8'h05, 8'h0F};
    for (int i = 0; i < 4; i++) write_reg(3'(i), vals[i]);
    repeat (9) @(posedge segled_str); // Frame in flight plus two full scans
    @(negedge sys_clk);
    for (int i = 0; i < 4; i++) begin
      compare_value($sformatf("digit %0d", i), SEG_TABLE[vals[i][3:0]], last_seg[i]);
    end
    end_test();
  endtask

  task automatic test_busy();
    logic [7:0] val;
    logic [7:0] got;
    start_test("busy_led");
    val = 8'($random(seed));
    uart_send(8'h85); // Write command, register 5
    compare_value("led waiting for data", 8'h01, {7'd0, led});
    uart_send(val);
    compare_value("led after write", 8'h00, {7'd0, led});
    fork
      uart_send(8'h05);
      uart_recv(got);
      begin
        @(negedge uart_tx_to_pc);
        repeat (CPB) @(negedge sys_clk);
        compare_value("led while sending", 8'h01, {7'd0, led});
      end
    join
    compare_value("register 5", val, got);
    repeat (CPB) @(negedge sys_clk); // Rest of the stop bit
    compare_value("led when idle", 8'h00, {7'd0, led});
    end_test();
  endtask

  task automatic test_back_to_back();
    logic [7:0] val;
    logic [7:0] got;
    start_test("back_to_back");
    val = 8'($random(seed));
    fork
      begin
        uart_send(8'h86);
        uart_send(val);
        uart_send(8'h06);
      end
      uart_recv(got);
    join
    compare_value("register 6", val, got);
    end_test();
  endtask

  initial begin
    arst_n          = 1'b0;
    key2            = 1'b0;
    uart_rx_from_pc = 1'b1; // Line idles high
    repeat (3) @(negedge sys_clk);
    arst_n = 1'b1;
    repeat (4) @(negedge sys_clk);
    test_reset();
    test_write_read();
    test_key();
    test_display();
    test_busy();
    test_back_to_back();
    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- flow_led.f
+incdir+verilog
verilog/flow_led_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_mcu.sv
verilog/seg_led_hex595.sv
verilog/flow_led.sv
dv/flow_led_tb.sv

//--- verilog/flow_led.sv
`timescale 1ns/1ps

module flow_led (
  input  logic sys_clk,         // 50 MHz board clock
  input  logic arst_n,          // From key1
  input  logic key2,
  input  logic uart_rx_from_pc,
  output logic uart_tx_to_pc,
  output logic led,
  output logic segled_clk,
  output logic segled_dat,
  output logic segled_str
);

  logic                busy;
  flow_led_pkg::byte_t out_pin0;
  flow_led_pkg::byte_t out_pin1;
  flow_led_pkg::byte_t out_pin2;
  flow_led_pkg::byte_t out_pin3;

  uart_mcu i_uart_mcu (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .uart_rxd (uart_rx_from_pc),
    .uart_txd (uart_tx_to_pc),
    .key2     (key2),
    .busy     (busy),
    .out_pin0 (out_pin0),
    .out_pin1 (out_pin1),
    .out_pin2 (out_pin2),
    .out_pin3 (out_pin3)
  );

  seg_led_hex595 i_seg_led_hex595 (
    .sys_clk (sys_clk),
    .arst_n  (arst_n),
    .data0   (out_pin0), // Low nibble of each register shown
    .data1   (out_pin1),
    .data2   (out_pin2),
    .data3   (out_pin3),
    .clk     (segled_clk),
    .dat     (segled_dat),
    .str     (segled_str)
  );

  assign led = busy;

endmodule

//--- verilog/flow_led_pkg.sv
package flow_led_pkg;

  typedef logic [7:0] byte_t; // UART byte or register value

  typedef logic [3:0] reg_idx_t; // Read index over registers and inputs

  // Active low, dp g f e d c b a
  typedef logic [7:0] seg_code_t;

  typedef enum logic [1:0] {
    idle,      // Waiting for a command byte
    wait_data, // Write command seen, data byte next
    send_resp  // Response held until transmitter is free
  } mcu_state_t;

endpackage

//--- verilog/flow_led_settings.svh
`ifndef FLOW_LED_SETTINGS_SVH
`define FLOW_LED_SETTINGS_SVH

// Small values keep simulation short
// A board build at 50 MHz uses 434 for 115200 baud

`define FLOW_LED_CLKS_PER_BIT 16 // sys_clk cycles per UART bit

`define FLOW_LED_SEG_DIV 2 // sys_clk cycles per half period of segled_clk

`define FLOW_LED_REG_COUNT 8 // Number of out_pin registers

`endif

//--- verilog/seg_led_hex595.sv
`timescale 1ns/1ps
`include "flow_led_settings.svh"

module seg_led_hex595 (
  input  logic                sys_clk,
  input  logic                arst_n,
  input  flow_led_pkg::byte_t data0,
  input  flow_led_pkg::byte_t data1,
  input  flow_led_pkg::byte_t data2,
  input  flow_led_pkg::byte_t data3,
  output logic                clk,
  output logic                dat,
  output logic                str
);

  localparam int DIV   = `FLOW_LED_SEG_DIV;
  localparam int DIV_W = $clog2(DIV + 1);
  localparam logic [5:0] STEP_LOAD = 6'd34; // Steps 0..31 bits, 32..33 strobe

  logic [DIV_W-1:0]    div_q;
  logic                tick;
  logic [5:0]          step_q, step_nxt;
  logic [1:0]          digit_q, digit_nxt;
  logic [15:0]         shift_q;
  logic                clk_q, str_q;
  logic [3:0]          nib_src;
  logic [7:0]          dig_sel;

  function automatic flow_led_pkg::seg_code_t hex_to_seg(input logic [3:0] hex);
    case (hex)
      4'h0: return 8'hC0;
      4'h1: return 8'hF9;
      4'h2: return 8'hA4;
      4'h3: return 8'hB0;
      4'h4: return 8'h99;
      4'h5: return 8'h92;
      4'h6: return 8'h82;
      4'h7: return 8'hF8;
      4'h8: return 8'h80;
      4'h9: return 8'h90;
      4'hA: return 8'h88;
      4'hB: return 8'h83;
      4'hC: return 8'hC6;
      4'hD: return 8'hA1;
      4'hE: return 8'h86;
      default: return 8'h8E;
    endcase
  endfunction

  assign tick      = (div_q == DIV_W'(DIV - 1));
  assign step_nxt  = (step_q == STEP_LOAD) ? 6'd0 : step_q + 1'b1;
  assign digit_nxt = digit_q + 1'b1;
  assign dig_sel   = {4'hF, ~(4'b0001 << digit_nxt)}; // Active low select

  always_comb begin
    case (digit_nxt)
      2'd0:    nib_src = data0[3:0];
      2'd1:    nib_src = data1[3:0];
      2'd2:    nib_src = data2[3:0];
      default: nib_src = data3[3:0];
    endcase
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_q   <= '0;
      step_q  <= STEP_LOAD; // First tick loads digit 0
      digit_q <= 2'd3;
      clk_q   <= 1'b0;
      str_q   <= 1'b0;
    end else if (tick) begin
      div_q   <= '0;
      step_q  <= step_nxt;
      clk_q   <= !step_nxt[5] && step_nxt[0]; // High in second half of each bit
      str_q   <= (step_nxt == 6'd32) || (step_nxt == 6'd33);
      if (step_q == STEP_LOAD) digit_q <= digit_nxt;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
    end else if (tick) begin
      if (step_q == STEP_LOAD) begin
        shift_q <= {hex_to_seg(nib_src), dig_sel};
      end else if (!step_q[5] && step_q[0]) begin
        shift_q <= {shift_q[14:0], 1'b0}; // Next bit after the rising edge
      end
    end
  end

  assign clk = clk_q;
  assign str = str_q;
  assign dat = shift_q[15]; // MSB first

  // Latch only once all 16 bits have left the shift register
  a_str_clk_low: assert property (@(posedge sys_clk) disable iff (!arst_n)
    str_q |-> !clk_q && (shift_q == '0));

endmodule

//--- verilog/uart_byte_if.sv
`timescale 1ns/1ps

interface uart_byte_if;
  flow_led_pkg::byte_t rx_data;  // Valid with rx_valid
  logic                rx_valid; // One-cycle strobe
  flow_led_pkg::byte_t tx_data;  // Sampled with tx_start
  logic                tx_start; // One-cycle strobe, only while idle
  logic                tx_busy;  // High for the whole frame

  modport rx_side (output rx_data, output rx_valid);

  modport tx_side (input tx_data, input tx_start, output tx_busy);

  modport engine (input rx_data, input rx_valid, input tx_busy,
                  output tx_data, output tx_start);

endinterface

//--- verilog/uart_mcu.sv
`timescale 1ns/1ps
`include "flow_led_settings.svh"

module uart_mcu (
  input  logic                sys_clk,
  input  logic                arst_n,
  input  logic                uart_rxd,
  output logic                uart_txd,
  input  logic                key2,
  output logic                busy,
  output flow_led_pkg::byte_t out_pin0,
  output flow_led_pkg::byte_t out_pin1,
  output flow_led_pkg::byte_t out_pin2,
  output flow_led_pkg::byte_t out_pin3
);

  uart_byte_if u_bus ();

  flow_led_pkg::mcu_state_t state_q;
  flow_led_pkg::byte_t      regs_q [`FLOW_LED_REG_COUNT];
  flow_led_pkg::byte_t      wr_cnt_q; // Completed writes, wraps at 256
  flow_led_pkg::byte_t      resp_q;
  flow_led_pkg::byte_t      rd_data;
  flow_led_pkg::byte_t      in_pin0;
  flow_led_pkg::byte_t      in_pin1;
  flow_led_pkg::reg_idx_t   rd_idx;
  logic [2:0]               wr_idx_q;
  logic                     key_s1, key_s2;

  uart_rx i_uart_rx (
    .sys_clk (sys_clk),
    .arst_n  (arst_n),
    .rxd     (uart_rxd),
    .bus     (u_bus.rx_side)
  );

  uart_tx i_uart_tx (
    .sys_clk (sys_clk),
    .arst_n  (arst_n),
    .txd     (uart_txd),
    .bus     (u_bus.tx_side)
  );

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      key_s1 <= 1'b0;
      key_s2 <= 1'b0;
    end else begin
      key_s1 <= key2;
      key_s2 <= key_s1;
    end
  end

  assign in_pin0 = {7'd0, key_s2};
  assign in_pin1 = wr_cnt_q;
  assign rd_idx  = u_bus.rx_data[3:0];

  always_comb begin
    case (rd_idx)
      4'd8:    rd_data = in_pin0;
      4'd9:    rd_data = in_pin1;
      default: rd_data = (rd_idx < `FLOW_LED_REG_COUNT) ? regs_q[rd_idx[2:0]] : 8'h00;
    endcase
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= flow_led_pkg::idle;
      wr_cnt_q <= '0;
      for (int i = 0; i < `FLOW_LED_REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      case (state_q)
        flow_led_pkg::idle: begin
          if (u_bus.rx_valid) begin
            state_q <= u_bus.rx_data[7] ? flow_led_pkg::wait_data : flow_led_pkg::send_resp;
          end
        end
        flow_led_pkg::wait_data: begin
          if (u_bus.rx_valid) begin
            regs_q[wr_idx_q] <= u_bus.rx_data;
            wr_cnt_q         <= wr_cnt_q + 1'b1;
            state_q          <= flow_led_pkg::idle;
          end
        end
        flow_led_pkg::send_resp: begin
          if (!u_bus.tx_busy) state_q <= flow_led_pkg::idle; // Start goes out now
        end
        default: state_q <= flow_led_pkg::idle;
      endcase
    end
  end

  // Index and response captured with every command byte
  always_ff @(posedge sys_clk) begin
    if (state_q == flow_led_pkg::idle && u_bus.rx_valid) begin
      wr_idx_q <= u_bus.rx_data[2:0];
      resp_q   <= rd_data;
    end
  end

  assign u_bus.tx_data  = resp_q;
  assign u_bus.tx_start = (state_q == flow_led_pkg::send_resp) && !u_bus.tx_busy;

  assign busy = (state_q != flow_led_pkg::idle) || u_bus.tx_busy;

  assign out_pin0 = regs_q[0];
  assign out_pin1 = regs_q[1];
  assign out_pin2 = regs_q[2];
  assign out_pin3 = regs_q[3];

  // Transmitter must accept every start strobe
  a_tx_start_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
    u_bus.tx_start |-> !u_bus.tx_busy ##1 u_bus.tx_busy);

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`include "flow_led_settings.svh"

module uart_rx (
  input  logic            sys_clk,
  input  logic            arst_n,
  input  logic            rxd,
  uart_byte_if.rx_side    bus
);

  localparam int CPB   = `FLOW_LED_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CPB / 2 - 1);

  typedef enum logic [1:0] {st_idle, st_start, st_bits, st_stop} rx_state_t;

  rx_state_t           state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [2:0]          bit_q;
  logic                rxd_s1, rxd_s2, rxd_s3;
  logic                valid_q;
  flow_led_pkg::byte_t shift_q;

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      rxd_s1 <= 1'b1; // Line idles high
      rxd_s2 <= 1'b1;
      rxd_s3 <= 1'b1;
    end else begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
      rxd_s3 <= rxd_s2; // Previous level for edge detect
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (rxd_s3 && !rxd_s2) begin // Falling edge
            state_q <= st_start;
            cnt_q   <= '0;
          end
        end
        st_start: begin
          if (cnt_q == CNT_HALF) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rxd_s2 ? st_idle : st_bits; // False start drops out
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        st_bits: begin
          if (cnt_q == CNT_LAST) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= st_stop;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin // Stop bit
          if (cnt_q == CNT_LAST) begin
            valid_q <= rxd_s2; // Bad stop bit loses the byte
            state_q <= st_idle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state_q == st_bits && cnt_q == CNT_LAST) begin
      shift_q <= {rxd_s2, shift_q[7:1]}; // LSB first
    end
  end

  assign bus.rx_data  = shift_q;
  assign bus.rx_valid = valid_q;

  a_valid_single: assert property (@(posedge sys_clk) disable iff (!arst_n)
    valid_q |=> !valid_q);

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`include "flow_led_settings.svh"

module uart_tx (
  input  logic            sys_clk,
  input  logic            arst_n,
  output logic            txd,
  uart_byte_if.tx_side    bus
);

  localparam int CPB   = `FLOW_LED_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);

  logic [9:0]       frame_q; // Stop, data, start
  logic [3:0]       bit_q;
  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_q <= '1;
      bit_q   <= '0;
      cnt_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (bus.tx_start) begin
        frame_q <= {1'b1, bus.tx_data, 1'b0};
        bit_q   <= '0;
        cnt_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (cnt_q == CNT_LAST) begin
      cnt_q   <= '0;
      frame_q <= {1'b1, frame_q[9:1]}; // Refill with idle level
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0; // Stop bit done
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign txd         = frame_q[0];
  assign bus.tx_busy = busy_q;

endmodule
